// File: sources.f
hdl/image_pkg.sv
hdl/dot_product3.sv
hdl/saturation_settings.sv
hdl/color_saturation.sv
hdl/yuv_saturation_top.sv
verif/yuv_saturation_assertions.sv
verif/tb_yuv_saturation.sv

// File: verif/tb_yuv_saturation.sv
`timescale 1ns/10ps
`default_nettype none

// table-driven testbench for the saturation stage
module tb_yuv_saturation;

   import image_pkg::*;

   localparam int N_DIRECTED = 24;
   localparam int N_ROWS     = N_DIRECTED + 40;
   localparam int CLK_PERIOD = 8;

   logic      clk;
   logic      resetb;
   strength_t strength;
   logic      enable;
   logic      dvi;
   dtype_t    dtypei;
   luma_t     yi;
   chroma_t   ui;
   chroma_t   vi;
   meta_t     meta_datai;
   logic      dvo;
   dtype_t    dtypeo;
   luma_t     yo;
   chroma_t   uo;
   chroma_t   vo;
   meta_t     meta_datao;

   // stimulus table, one entry per input word
   logic      tb_valid    [N_ROWS];
   dtype_t    tb_dtype    [N_ROWS];
   luma_t     tb_y        [N_ROWS];
   chroma_t   tb_u        [N_ROWS];
   chroma_t   tb_v        [N_ROWS];
   meta_t     tb_meta     [N_ROWS];
   strength_t tb_strength [N_ROWS];
   logic      tb_enable   [N_ROWS];
   // expected payload from the reference model
   luma_t     exp_y       [N_ROWS];
   chroma_t   exp_u       [N_ROWS];
   chroma_t   exp_v       [N_ROWS];

   integer seed;
   int     n_rows;
   int     valid_errors;
   int     dtype_errors;
   int     meta_errors;
   int     luma_errors;
   int     chroma_errors;

   yuv_saturation_top DUT (
      .clk        (clk),
      .resetb     (resetb),
      .strength   (strength),
      .enable     (enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .yi         (yi),
      .ui         (ui),
      .vi         (vi),
      .meta_datai (meta_datai),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .yo         (yo),
      .uo         (uo),
      .vo         (vo),
      .meta_datao (meta_datao)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // run length is reset plus one row per cycle, with margin
   initial begin
      #((N_ROWS + 20) * CLK_PERIOD);
      $display("timeout: the stimulus table did not finish in time");
      $display("Testbench failed");
      $finish;
   end

   // division that rounds toward minus infinity, den > 0
   function automatic int floor_div(input int num, input int den);
      int q;
      q = num / den;
      if ((num % den != 0) && (num < 0)) begin
         q = q - 1;
      end
      floor_div = q;
   endfunction

   // y' = y - (89*s*u + 43*s*v)/16384, clamped to 0..255
   function automatic luma_t model_luma(input luma_t y, input chroma_t u, input chroma_t v,
                                        input strength_t s);
      int t;
      t = floor_div(16384 * int'(y) - 89 * int'(s) * int'(u) - 43 * int'(s) * int'(v), 16384);
      if (t < 0) t = 0;
      if (t > 255) t = 255;
      model_luma = luma_t'(t);
   endfunction

   // c' = c*(3s + 256)/256, clamped to -128..127
   function automatic chroma_t model_chroma(input chroma_t c, input strength_t s);
      int t;
      t = floor_div(int'(c) * (3 * int'(s) + 256), 256);
      if (t < -128) t = -128;
      if (t > 127) t = 127;
      model_chroma = chroma_t'(t);
   endfunction

   task automatic add_row(input logic valid, input dtype_t dtype, input luma_t y,
                          input chroma_t u, input chroma_t v, input meta_t meta,
                          input strength_t s, input logic en);
      tb_valid[n_rows]    = valid;
      tb_dtype[n_rows]    = dtype;
      tb_y[n_rows]        = y;
      tb_u[n_rows]        = u;
      tb_v[n_rows]        = v;
      tb_meta[n_rows]     = meta;
      tb_strength[n_rows] = s;
      tb_enable[n_rows]   = en;
      n_rows++;
   endtask

   task automatic build_table();
      int     i;
      int     pick;
      dtype_t kind;
      // enable low, pixels pass untouched
      add_row(1'b1, DTYPE_FRAME_START, 8'd0, 8'sd0, 8'sd0, 16'h0a00, 8'd64, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd100, 8'sd50, -8'sd30, 16'h0a01, 8'd64, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd200, -8'sd100, 8'sd90, 16'h0a02, 8'd64, 1'b0);
      add_row(1'b1, DTYPE_LINE_START, 8'd10, 8'sd20, 8'sd30, 16'h0a03, 8'd0, 1'b1);
      // strength 0 is the identity for chroma
      add_row(1'b1, DTYPE_FRAME_START, 8'd0, 8'sd0, 8'sd0, 16'h0a04, 8'd0, 1'b1);
      add_row(1'b1, DTYPE_PIXEL, 8'd77, -8'sd77, 8'sd60, 16'h0a05, 8'd0, 1'b1);
      // half strength, then chroma and luma clamping
      add_row(1'b1, DTYPE_FRAME_START, 8'd0, 8'sd0, 8'sd0, 16'h0a06, 8'd128, 1'b1);
      add_row(1'b1, DTYPE_PIXEL, 8'd120, 8'sd40, -8'sd20, 16'h0a07, 8'd128, 1'b1);
      add_row(1'b1, DTYPE_PIXEL, 8'd90, 8'sd100, -8'sd100, 16'h0a08, 8'd128, 1'b1);
      add_row(1'b1, DTYPE_PIXEL, 8'd250, -8'sd100, -8'sd100, 16'h0a09, 8'd128, 1'b1);
      add_row(1'b1, DTYPE_PIXEL, 8'd5, 8'sd100, 8'sd100, 16'h0a0a, 8'd128, 1'b1);
      // non-pixel words keep their payload while enabled
      add_row(1'b1, DTYPE_LINE_END, 8'd33, 8'sd100, -8'sd100, 16'h0a0b, 8'd128, 1'b1);
      add_row(1'b1, DTYPE_LINE_START, 8'd44, -8'sd90, 8'sd90, 16'h0a0c, 8'd255, 1'b1);
      add_row(1'b1, DTYPE_FRAME_END, 8'd55, 8'sd120, -8'sd120, 16'h0a0d, 8'd255, 1'b1);
      add_row(1'b1, DTYPE_FRAME_START, 8'd66, 8'sd70, -8'sd70, 16'h0a0e, 8'd255, 1'b1);
      // full strength, small chroma checks rounding down
      // requested settings change here but must wait for a frame start
      add_row(1'b1, DTYPE_PIXEL, 8'd128, -8'sd1, 8'sd1, 16'h0a0f, 8'd10, 1'b0);
      add_row(1'b0, DTYPE_PIXEL, 8'd128, 8'sd10, -8'sd10, 16'h0a10, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd128, 8'sd10, -8'sd10, 16'h0a11, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd0, 8'sd127, -8'sd128, 16'h0a12, 8'd10, 1'b0);
      // an invalid frame start loads nothing
      add_row(1'b0, DTYPE_FRAME_START, 8'd0, 8'sd0, 8'sd0, 16'h0a13, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd60, -8'sd50, 8'sd50, 16'h0a14, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_FRAME_START, 8'd0, 8'sd0, 8'sd0, 16'h0a15, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd60, -8'sd50, 8'sd50, 16'h0a16, 8'd10, 1'b0);
      add_row(1'b1, DTYPE_PIXEL, 8'd255, 8'sd127, -8'sd128, 16'h0a17, 8'd10, 1'b0);
      // random words, mostly valid pixels
      for (i = 0; i < N_ROWS - N_DIRECTED; i++) begin
         pick = $random(seed) & 7;
         case (pick)
            5:       kind = DTYPE_LINE_START;
            6:       kind = DTYPE_LINE_END;
            7:       kind = DTYPE_FRAME_START;
            default: kind = DTYPE_PIXEL;
         endcase
         add_row(($random(seed) & 3) != 0, kind, luma_t'($random(seed)),
                 chroma_t'($random(seed)), chroma_t'($random(seed)), meta_t'($random(seed)),
                 strength_t'($random(seed)), 1'($random(seed)));
      end
   endtask

   // walk the table with the active settings the DUT should hold
   task automatic compute_expected();
      strength_t act_s;
      logic      act_en;
      int        i;
      act_s  = '0;
      act_en = 1'b0;
      for (i = 0; i < n_rows; i++) begin
         if (act_en && (tb_dtype[i] == DTYPE_PIXEL)) begin
            exp_y[i] = model_luma(tb_y[i], tb_u[i], tb_v[i], act_s);
            exp_u[i] = model_chroma(tb_u[i], act_s);
            exp_v[i] = model_chroma(tb_v[i], act_s);
         end else begin
            exp_y[i] = tb_y[i];
            exp_u[i] = tb_u[i];
            exp_v[i] = tb_v[i];
         end
         // frame start only affects the words after it
         if (tb_valid[i] && (tb_dtype[i] == DTYPE_FRAME_START)) begin
            act_s  = tb_strength[i];
            act_en = tb_enable[i];
         end
      end
   endtask

   task automatic check_valid(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, expected, actual);
         valid_errors++;
      end
   endtask

   task automatic check_dtype(input string name, input dtype_t expected, input dtype_t actual);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
         dtype_errors++;
      end
   endtask

   task automatic check_meta(input string name, input meta_t expected, input meta_t actual);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
         meta_errors++;
      end
   endtask

   task automatic check_luma(input string name, input luma_t expected, input luma_t actual);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
         luma_errors++;
      end
   endtask

   task automatic check_chroma(input string name, input chroma_t expected,
                               input chroma_t actual);
      if (actual !== expected) begin
         $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
         chroma_errors++;
      end
   endtask

   task automatic check_row(input int i);
      check_valid("dvo", tb_valid[i], dvo);
      check_dtype("dtypeo", tb_dtype[i], dtypeo);
      check_meta("meta_datao", tb_meta[i], meta_datao);
      check_luma("yo", exp_y[i], yo);
      check_chroma("uo", exp_u[i], uo);
      check_chroma("vo", exp_v[i], vo);
   endtask

   initial begin
      int i;
      int total;
      // a busy stream during reset, which the outputs must not pick up
      resetb        = 1'b0;
      strength      = '0;
      enable        = 1'b0;
      dvi           = 1'b1;
      dtypei        = DTYPE_PIXEL;
      yi            = 8'd200;
      ui            = 8'sd100;
      vi            = -8'sd100;
      meta_datai    = 16'hbeef;
      seed          = 90;
      n_rows        = 0;
      valid_errors  = 0;
      dtype_errors  = 0;
      meta_errors   = 0;
      luma_errors   = 0;
      chroma_errors = 0;
      build_table();
      compute_expected();
      repeat (3) @(posedge clk);
      // valid drops first, so the first edge out of reset sees an idle stream
      dvi <= 1'b0;
      @(posedge clk);
      dtypei     <= '0;
      yi         <= '0;
      ui         <= '0;
      vi         <= '0;
      meta_datai <= '0;
      // outputs still hold their reset values
      @(negedge clk);
      check_valid("dvo", 1'b0, dvo);
      check_dtype("dtypeo", '0, dtypeo);
      check_meta("meta_datao", '0, meta_datao);
      check_luma("yo", '0, yo);
      check_chroma("uo", '0, uo);
      check_chroma("vo", '0, vo);
      @(posedge clk);
      resetb <= 1'b1;
      // drive row i, then check row i-1 mid-cycle
      for (i = 0; i <= n_rows; i++) begin
         @(posedge clk);
         if (i < n_rows) begin
            dvi        <= tb_valid[i];
            dtypei     <= tb_dtype[i];
            yi         <= tb_y[i];
            ui         <= tb_u[i];
            vi         <= tb_v[i];
            meta_datai <= tb_meta[i];
            strength   <= tb_strength[i];
            enable     <= tb_enable[i];
         end else begin
            dvi <= 1'b0;
         end
         @(negedge clk);
         if (i > 0) begin
            check_row(i - 1);
         end
      end
      total = valid_errors + dtype_errors + meta_errors + luma_errors + chroma_errors
              + DUT.checks.failures;
      $display("errors: valid %0d dtype %0d meta %0d luma %0d chroma %0d assertions %0d",
               valid_errors, dtype_errors, meta_errors, luma_errors, chroma_errors,
               DUT.checks.failures);
      if (total == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/yuv_saturation_assertions.sv
`timescale 1ns/10ps
`default_nettype none

// stream properties of the saturation top
module yuv_saturation_assertions (
   input wire                     clk,
   input wire                     resetb,
   input wire                     dvi,
   input wire image_pkg::dtype_t  dtypei,
   input wire image_pkg::luma_t   yi,
   input wire image_pkg::chroma_t ui,
   input wire image_pkg::chroma_t vi,
   input wire                     dvo,
   input wire image_pkg::luma_t   yo,
   input wire image_pkg::chroma_t uo,
   input wire image_pkg::chroma_t vo
);

   import image_pkg::*;

   // number of failed assertions, read back by the testbench
   int failures = 0;

   // valid is delayed by exactly one edge
   valid_latency: assert property (@(posedge clk) disable iff (!resetb) dvo == $past(dvi))
      else begin
         $error("dvo does not follow dvi by one cycle");
         failures++;
      end

   // non-pixel words carry their payload through unchanged
   non_pixel_passes: assert property (@(posedge clk) disable iff (!resetb)
      (dtypei != DTYPE_PIXEL) |=> (yo == $past(yi)) && (uo == $past(ui)) && (vo == $past(vi)))
      else begin
         $error("payload of a non-pixel word was altered");
         failures++;
      end

   // no valid word while reset is held
   reset_clears_valid: assert property (@(posedge clk) !resetb |-> !dvo)
      else begin
         $error("dvo is high during reset");
         failures++;
      end

endmodule

bind yuv_saturation_top yuv_saturation_assertions checks (
   .clk    (clk),
   .resetb (resetb),
   .dvi    (dvi),
   .dtypei (dtypei),
   .yi     (yi),
   .ui     (ui),
   .vi     (vi),
   .dvo    (dvo),
   .yo     (yo),
   .uo     (uo),
   .vo     (vo)
);

`default_nettype wire

// File: hdl/yuv_saturation_top.sv
`timescale 1ns/10ps
`default_nettype none

// saturation stage of the camera pipeline
// one cycle latency, one word per cycle, no back-pressure
module yuv_saturation_top (
   input  wire                        clk,
   input  wire                        resetb,
   input  wire image_pkg::strength_t  strength,
   input  wire                        enable,
   input  wire                        dvi,
   input  wire image_pkg::dtype_t     dtypei,
   input  wire image_pkg::luma_t      yi,
   input  wire image_pkg::chroma_t    ui,
   input  wire image_pkg::chroma_t    vi,
   input  wire image_pkg::meta_t      meta_datai,
   output logic                       dvo,
   output image_pkg::dtype_t          dtypeo,
   output image_pkg::luma_t           yo,
   output image_pkg::chroma_t         uo,
   output image_pkg::chroma_t         vo,
   output image_pkg::meta_t           meta_datao
);

   import image_pkg::*;

   // settings latched on frame start
   strength_t active_strength;
   logic      active_enable;

   saturation_settings settings (
      .clk             (clk),
      .resetb          (resetb),
      .dvi             (dvi),
      .dtypei          (dtypei),
      .strength        (strength),
      .enable          (enable),
      .active_strength (active_strength),
      .active_enable   (active_enable)
   );

   color_saturation saturation (
      .clk             (clk),
      .resetb          (resetb),
      .active_enable   (active_enable),
      .active_strength (active_strength),
      .dvi             (dvi),
      .dtypei          (dtypei),
      .yi              (yi),
      .ui              (ui),
      .vi              (vi),
      .meta_datai      (meta_datai),
      .dvo             (dvo),
      .dtypeo          (dtypeo),
      .yo              (yo),
      .uo              (uo),
      .vo              (vo),
      .meta_datao      (meta_datao)
   );

endmodule

`default_nettype wire

// File: hdl/color_saturation.sv
`timescale 1ns/10ps
`default_nettype none

// colour saturation in yuv space
// the rgb matrix collapses so only y needs a dot product
// u and v each take a single gain of 1 + 3*strength
module color_saturation (
   input  wire                        clk,
   input  wire                        resetb,
   input  wire                        active_enable,
   input  wire image_pkg::strength_t  active_strength,
   input  wire                        dvi,
   input  wire image_pkg::dtype_t     dtypei,
   input  wire image_pkg::luma_t      yi,
   input  wire image_pkg::chroma_t    ui,
   input  wire image_pkg::chroma_t    vi,
   input  wire image_pkg::meta_t      meta_datai,
   output logic                       dvo,
   output image_pkg::dtype_t          dtypeo,
   output image_pkg::luma_t           yo,
   output image_pkg::chroma_t         uo,
   output image_pkg::chroma_t         vo,
   output image_pkg::meta_t           meta_datao
);

   import image_pkg::*;

   // floor of prod/256 clamped into -128..127
   function automatic chroma_t clamp_chroma(
      input logic signed [CHROMA_PROD_WIDTH-1:0] prod
   );
      logic signed [CHROMA_PROD_WIDTH-STRENGTH_WIDTH-1:0] whole;
      whole = prod[CHROMA_PROD_WIDTH-1:STRENGTH_WIDTH];
      // in range when the bits above bit 7 all match the sign
      if (!whole[$bits(whole)-1] && (|whole[$bits(whole)-2:PIXEL_WIDTH-1])) begin
         clamp_chroma = 8'sh7f;
      end else if (whole[$bits(whole)-1] && !(&whole[$bits(whole)-2:PIXEL_WIDTH-1])) begin
         clamp_chroma = 8'sh80;
      end else begin
         clamp_chroma = whole[PIXEL_WIDTH-1:0];
      end
   endfunction

   logic signed [SAMPLE_WIDTH-1:0]      y_ext;
   logic signed [SAMPLE_WIDTH-1:0]      u_ext;
   logic signed [SAMPLE_WIDTH-1:0]      v_ext;
   logic signed [DP_COEFF_WIDTH-1:0]    coeff_y;
   logic signed [DP_COEFF_WIDTH-1:0]    coeff_u;
   logic signed [DP_COEFF_WIDTH-1:0]    coeff_v;
   logic signed [DP_SUM_WIDTH-1:0]      y_sum;
   luma_t                               y_sat;
   logic        [GAIN_WIDTH-1:0]        uv_gain;
   logic signed [CHROMA_PROD_WIDTH-1:0] u_prod;
   logic signed [CHROMA_PROD_WIDTH-1:0] v_prod;
   logic                                do_sat;

   // grow by one bit, luma gets a zero sign bit
   assign y_ext = {1'b0, yi};
   assign u_ext = {ui[PIXEL_WIDTH-1], ui};
   assign v_ext = {vi[PIXEL_WIDTH-1], vi};

   // y row coefficients with 14 fraction bits
   // base is 1.0 moved up past the strength fraction
   assign coeff_y = {Y_COEFF_BASE, {STRENGTH_WIDTH{1'b0}}};
   assign coeff_u = Y_COEFF_U * $signed({1'b0, active_strength});
   assign coeff_v = Y_COEFF_V * $signed({1'b0, active_strength});

   dot_product3 y_dot_product (
      .a0 (y_ext),
      .a1 (u_ext),
      .a2 (v_ext),
      .b0 (coeff_y),
      .b1 (coeff_u),
      .b2 (coeff_v),
      .y  (y_sum)
   );

   // clamp luma to 0..255, dropping the fraction rounds down
   always_comb begin
      if (y_sum[DP_SUM_WIDTH-1]) begin
         y_sat = '0;
      end else if (|y_sum[DP_SUM_WIDTH-2:Y_FRAC_BITS+PIXEL_WIDTH]) begin
         y_sat = '1;
      end else begin
         y_sat = y_sum[Y_FRAC_BITS +: PIXEL_WIDTH];
      end
   end

   // chroma gain 3*strength + 1.0, at most 1021/256
   assign uv_gain = GAIN_WIDTH'(3 * active_strength) + GAIN_WIDTH'(1 << STRENGTH_WIDTH);

   // gain is unsigned, so pad a zero before the signed multiply
   assign u_prod = ui * $signed({1'b0, uv_gain});
   assign v_prod = vi * $signed({1'b0, uv_gain});

   // only pixels are touched, and only while enabled
   assign do_sat = active_enable && (dtypei == DTYPE_PIXEL);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         dtypeo     <= '0;
         yo         <= '0;
         uo         <= '0;
         vo         <= '0;
         meta_datao <= '0;
      end else begin
         // fields register every cycle, valid just follows
         dvo        <= dvi;
         dtypeo     <= dtypei;
         meta_datao <= meta_datai;
         yo         <= do_sat ? y_sat : yi;
         uo         <= do_sat ? clamp_chroma(u_prod) : ui;
         vo         <= do_sat ? clamp_chroma(v_prod) : vi;
      end
   end

endmodule

`default_nettype wire

// File: hdl/saturation_settings.sv
`timescale 1ns/10ps
`default_nettype none

// holds the strength and enable used by the datapath
// software may change the requested levels at any time, but they only
// reach the datapath on a frame start, so a picture is never split
module saturation_settings (
   input  wire                        clk,
   input  wire                        resetb,
   input  wire                        dvi,
   input  wire image_pkg::dtype_t     dtypei,
   input  wire image_pkg::strength_t  strength,
   input  wire                        enable,
   output image_pkg::strength_t       active_strength,
   output logic                       active_enable
);

   import image_pkg::*;

   logic frame_start;

   // only a valid word counts as a frame start
   assign frame_start = dvi && (dtypei == DTYPE_FRAME_START);

   // load on the frame-start edge
   // the frame-start word itself still sees the old values
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         // saturation off until the first frame start
         active_strength <= '0;
         active_enable   <= 1'b0;
      end else if (frame_start) begin
         active_strength <= strength;
         active_enable   <= enable;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dot_product3.sv
`timescale 1ns/10ps
`default_nettype none

// signed three-term dot product, purely combinational
// shared with the colour-matrix stages
module dot_product3 (
   input  wire signed [image_pkg::SAMPLE_WIDTH-1:0]   a0,
   input  wire signed [image_pkg::SAMPLE_WIDTH-1:0]   a1,
   input  wire signed [image_pkg::SAMPLE_WIDTH-1:0]   a2,
   input  wire signed [image_pkg::DP_COEFF_WIDTH-1:0] b0,
   input  wire signed [image_pkg::DP_COEFF_WIDTH-1:0] b1,
   input  wire signed [image_pkg::DP_COEFF_WIDTH-1:0] b2,
   output logic signed [image_pkg::DP_SUM_WIDTH-1:0]  y
);

   import image_pkg::*;

   // products at full sum width so nothing wraps
   logic signed [DP_SUM_WIDTH-1:0] prod0;
   logic signed [DP_SUM_WIDTH-1:0] prod1;
   logic signed [DP_SUM_WIDTH-1:0] prod2;

   // operands are sign extended to the result width
   assign prod0 = a0 * b0;
   assign prod1 = a1 * b1;
   assign prod2 = a2 * b2;

   // two guard bits hold the worst-case sum
   assign y = prod0 + prod1 + prod2;

endmodule

`default_nettype wire

// File: hdl/image_pkg.sv
`default_nettype none

package image_pkg;

   // stream word widths
   localparam int PIXEL_WIDTH    = 8;
   localparam int STRENGTH_WIDTH = 8;
   localparam int COEFF_WIDTH    = 8;
   localparam int DTYPE_WIDTH    = 4;
   localparam int META_WIDTH     = 16;

   // y-term coefficient format is s1.6
   localparam int COEFF_FRAC_BITS = 6;

   // dot product operand and sum widths
   // samples grow by one bit so luma can be treated as signed
   localparam int SAMPLE_WIDTH   = PIXEL_WIDTH + 1;
   localparam int DP_COEFF_WIDTH = STRENGTH_WIDTH + COEFF_WIDTH;
   // two guard bits cover the sum of three products
   localparam int DP_SUM_WIDTH   = SAMPLE_WIDTH + DP_COEFF_WIDTH + 2;
   // fraction bits left in the dot product after strength scaling
   localparam int Y_FRAC_BITS    = COEFF_FRAC_BITS + STRENGTH_WIDTH;

   // chroma gain 1.0 + 3*strength, needs two integer bits
   localparam int GAIN_WIDTH        = STRENGTH_WIDTH + 2;
   // signed chroma times zero-extended gain
   localparam int CHROMA_PROD_WIDTH = PIXEL_WIDTH + GAIN_WIDTH + 1;

   typedef logic        [PIXEL_WIDTH-1:0]    luma_t;
   typedef logic signed [PIXEL_WIDTH-1:0]    chroma_t;
   typedef logic        [STRENGTH_WIDTH-1:0] strength_t;
   typedef logic        [DTYPE_WIDTH-1:0]    dtype_t;
   typedef logic        [META_WIDTH-1:0]     meta_t;

   // data-type codes carried on dtype
   localparam dtype_t DTYPE_FRAME_START = 4'd1;
   localparam dtype_t DTYPE_FRAME_END   = 4'd2;
   localparam dtype_t DTYPE_LINE_START  = 4'd3;
   localparam dtype_t DTYPE_LINE_END    = 4'd4;
   localparam dtype_t DTYPE_PIXEL       = 4'd8;

   // yuv form of the rgb saturation matrix, y row
   // 1.0 for the luma term
   localparam logic signed [COEFF_WIDTH-1:0] Y_COEFF_BASE = 8'sd64;
   // -1.39, scaled by strength for u
   localparam logic signed [COEFF_WIDTH-1:0] Y_COEFF_U    = -8'sd89;
   // -0.67, scaled by strength for v
   localparam logic signed [COEFF_WIDTH-1:0] Y_COEFF_V    = -8'sd43;

endpackage

`default_nettype wire
